// ==== p4_router_pkg.sv ====
// Shared types, port-id constants and port translation for the IPv4 router datapath
// Referenced by scoped names from every stage

package p4_router_pkg;

    ////////////////////
    // Basic types

    typedef logic [7:0]  rtl_port_t;
    typedef logic [7:0]  p4_port_t;
    typedef logic [15:0] checksum_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [1:0]  drop_reason_t;

    // Wire order, first field in the top bits
    typedef struct packed {
        logic [7:0]  version_ihl;
        logic [7:0]  tos;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [15:0] flags_fragment;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        checksum_t   header_checksum;
        ipv4_addr_t  src_addr;
        ipv4_addr_t  dst_addr;
    } ipv4_header_t;

    typedef struct packed {
        ipv4_header_t header;
        p4_port_t     ingress_id;
        p4_port_t     egress_id;
        logic         chk_good;
        logic         ttl_expired;
    } route_stage_t;

    ////////////////////
    // Drop codes, listed by priority

    localparam drop_reason_t DROP_NONE         = 2'd0;
    localparam drop_reason_t DROP_BAD_CHECKSUM = 2'd1;
    localparam drop_reason_t DROP_TTL_EXPIRED  = 2'd2;
    localparam drop_reason_t DROP_NO_ROUTE     = 2'd3;

    ////////////////////
    // Pipeline port ids

    localparam p4_port_t P4_CPU     = 8'h00;
    localparam p4_port_t P4_HDR0    = 8'h10;
    localparam p4_port_t P4_HDR1    = 8'h11;
    localparam p4_port_t P4_OISL0   = 8'h20;
    localparam p4_port_t P4_OISL1   = 8'h21;
    localparam p4_port_t P4_ECP0    = 8'h30;
    localparam p4_port_t P4_ECP1    = 8'h31;
    localparam p4_port_t P4_ECG0    = 8'h40;
    localparam p4_port_t P4_ECG1    = 8'h41;
    localparam p4_port_t P4_ECG2    = 8'h42;
    localparam p4_port_t P4_ECG3    = 8'h43;
    localparam p4_port_t P4_UNKNOWN = 8'hFF;

    // RTL indices that a p4 id can demap to
    localparam rtl_port_t RTL_CPU       = 8'd0;
    localparam rtl_port_t RTL_OISL0_D0  = 8'd1;
    localparam rtl_port_t RTL_OISL1_D0  = 8'd3;
    localparam rtl_port_t RTL_ECP0      = 8'd5;
    localparam rtl_port_t RTL_ECP1      = 8'd6;
    localparam rtl_port_t RTL_HDR0      = 8'd7;
    localparam rtl_port_t RTL_HDR1      = 8'd8;
    localparam rtl_port_t RTL_ECG0      = 8'd9;
    localparam rtl_port_t RTL_ECG1      = 8'd10;
    localparam rtl_port_t RTL_ECG2      = 8'd11;
    localparam rtl_port_t RTL_ECG3      = 8'd12;
    localparam rtl_port_t RTL_NUM_PORTS = 8'd13;
    localparam rtl_port_t RTL_UNKNOWN   = 8'hFF;

    // Indexed by RTL port, both OISL lanes share one id
    localparam p4_port_t PORT_MAP_TABLE [13] = '{
        P4_CPU, P4_OISL0, P4_OISL0, P4_OISL1, P4_OISL1, P4_ECP0, P4_ECP1,
        P4_HDR0, P4_HDR1, P4_ECG0, P4_ECG1, P4_ECG2, P4_ECG3
    };

    ////////////////////
    // Functions

    function automatic p4_port_t port_map(input rtl_port_t idx);
        p4_port_t id;
        id = P4_UNKNOWN;
        if (idx < RTL_NUM_PORTS) begin
            id = PORT_MAP_TABLE[idx[3:0]];
        end
        return id;
    endfunction

    function automatic rtl_port_t port_demap(input p4_port_t id);
        rtl_port_t idx;
        case (id)
            P4_CPU   : idx = RTL_CPU;
            P4_OISL0 : idx = RTL_OISL0_D0;
            P4_OISL1 : idx = RTL_OISL1_D0;
            P4_ECP0  : idx = RTL_ECP0;
            P4_ECP1  : idx = RTL_ECP1;
            P4_HDR0  : idx = RTL_HDR0;
            P4_HDR1  : idx = RTL_HDR1;
            P4_ECG0  : idx = RTL_ECG0;
            P4_ECG1  : idx = RTL_ECG1;
            P4_ECG2  : idx = RTL_ECG2;
            P4_ECG3  : idx = RTL_ECG3;
            default  : idx = RTL_UNKNOWN;
        endcase
        return idx;
    endfunction

    // Ones' complement add with end-around carry
    function automatic checksum_t ones_add(input checksum_t a, input checksum_t b);
        logic [16:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[15:0] + {15'd0, sum[16]};
    endfunction

endpackage

// ==== ingress_port_mapper.sv ====
// Input stage: registers each arriving header and maps the RTL ingress index
// to the pipeline port id

`timescale 1ns/1ps

module ingress_port_mapper (
    input  logic                        packet_data_in,
    input  logic                        rst_n,

    input  logic                        in_valid,
    input  p4_router_pkg::ipv4_header_t in_header,
    input  p4_router_pkg::rtl_port_t    in_port,

    output logic                        map_valid,
    output p4_router_pkg::ipv4_header_t map_header,
    output p4_router_pkg::p4_port_t     map_ingress_id
);

    p4_router_pkg::p4_port_t ingress_id;

    // Out of range indices become 0xFF and ride along
    assign ingress_id = p4_router_pkg::port_map(in_port);

    ////////////////////
    // Stage register

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            map_valid <= 1'b0;
        end else begin
            map_valid <= in_valid;
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (in_valid) begin
            map_header     <= in_header;
            map_ingress_id <= ingress_id;
        end
    end

endmodule

// ==== ipv4_checksum_verify.sv ====
// Header checksum check: ones' complement sum of the ten header words,
// good when the folded sum is all ones

`timescale 1ns/1ps

module ipv4_checksum_verify (
    input  logic                        packet_data_in,
    input  logic                        rst_n,

    input  logic                        map_valid,
    input  p4_router_pkg::ipv4_header_t map_header,
    input  p4_router_pkg::p4_port_t     map_ingress_id,

    output logic                        chk_valid,
    output p4_router_pkg::ipv4_header_t chk_header,
    output p4_router_pkg::p4_port_t     chk_ingress_id,
    output logic                        chk_good
);

    p4_router_pkg::checksum_t header_sum;

    // Walk the header from the first word on the wire
    always_comb begin
        logic [159:0] hdr_bits;
        hdr_bits   = map_header;
        header_sum = '0;
        for (int i = 0; i < 10; i++) begin
            header_sum = p4_router_pkg::ones_add(header_sum, hdr_bits[159 - 16*i -: 16]);
        end
    end

    ////////////////////
    // Stage register

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= map_valid;
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (map_valid) begin
            chk_header     <= map_header;
            chk_ingress_id <= map_ingress_id;
            chk_good       <= (header_sum == 16'hFFFF);
        end
    end

endmodule

// ==== ipv4_route_update.sv ====
// Route lookup and TTL update stage; holds the software-written route table
// and rewrites TTL and checksum for headers that will be forwarded

`timescale 1ns/1ps

module ipv4_route_update #(
    parameter int ROUTE_ENTRIES = 16
) (
    input  logic                             packet_data_in,
    input  logic                             rst_n,

    // Route table write port
    input  logic                             route_wr,
    input  logic [$clog2(ROUTE_ENTRIES)-1:0] route_index,
    input  p4_router_pkg::p4_port_t          route_port,

    input  logic                             chk_valid,
    input  p4_router_pkg::ipv4_header_t      chk_header,
    input  p4_router_pkg::p4_port_t          chk_ingress_id,
    input  logic                             chk_good,

    output logic                             rt_valid,
    output p4_router_pkg::route_stage_t      rt_stage
);

    localparam int IDX_W = $clog2(ROUTE_ENTRIES);

    p4_router_pkg::p4_port_t      route_table [ROUTE_ENTRIES];
    p4_router_pkg::p4_port_t      egress_id;
    p4_router_pkg::ipv4_header_t  header_next;
    p4_router_pkg::checksum_t     new_checksum;
    logic [7:0]                   new_ttl;
    logic                         ttl_expired;
    logic                         will_forward;

    ////////////////////
    // Route table

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ROUTE_ENTRIES; i++) begin
                route_table[i] <= p4_router_pkg::P4_UNKNOWN;
            end
        end else if (route_wr) begin
            route_table[route_index] <= route_port;
        end
    end

    // A write lands at the edge, so a lookup in the same cycle sees the old entry
    assign egress_id = route_table[chk_header.dst_addr[IDX_W-1:0]];

    ////////////////////
    // TTL and incremental checksum

    assign ttl_expired  = (chk_header.ttl <= 8'd1);
    assign new_ttl      = chk_header.ttl - 8'd1;
    assign will_forward = chk_good && !ttl_expired &&
                          (p4_router_pkg::port_demap(egress_id) != p4_router_pkg::RTL_UNKNOWN);

    // HC' = ~(~HC + ~m + m'), m being the TTL/protocol word
    assign new_checksum = ~p4_router_pkg::ones_add(
        p4_router_pkg::ones_add(~chk_header.header_checksum,
                                ~{chk_header.ttl, chk_header.protocol}),
        {new_ttl, chk_header.protocol});

    always_comb begin
        header_next = chk_header;
        // Drops keep the header as it arrived
        if (will_forward) begin
            header_next.ttl             = new_ttl;
            header_next.header_checksum = new_checksum;
        end
    end

    ////////////////////
    // Stage register

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            rt_valid <= 1'b0;
        end else begin
            rt_valid <= chk_valid;
        end
    end

    always_ff @(posedge packet_data_in) begin
        if (chk_valid) begin
            rt_stage.header      <= header_next;
            rt_stage.ingress_id  <= chk_ingress_id;
            rt_stage.egress_id   <= egress_id;
            rt_stage.chk_good    <= chk_good;
            rt_stage.ttl_expired <= ttl_expired;
        end
    end

endmodule

// ==== egress_port_demapper.sv ====
// Output stage: demaps port ids back to RTL indices and either forwards
// the header or reports a drop with its reason

`timescale 1ns/1ps

module egress_port_demapper (
    input  logic                         packet_data_in,
    input  logic                         rst_n,

    input  logic                         rt_valid,
    input  p4_router_pkg::route_stage_t  rt_stage,

    output logic                         out_valid,
    output p4_router_pkg::ipv4_header_t  out_header,
    output p4_router_pkg::rtl_port_t     out_ingress_port,
    output p4_router_pkg::rtl_port_t     out_egress_port,
    output logic                         drop_valid,
    output p4_router_pkg::drop_reason_t  drop_reason
);

    p4_router_pkg::rtl_port_t     ingress_port;
    p4_router_pkg::rtl_port_t     egress_port;
    p4_router_pkg::drop_reason_t  reason;

    assign ingress_port = p4_router_pkg::port_demap(rt_stage.ingress_id);
    assign egress_port  = p4_router_pkg::port_demap(rt_stage.egress_id);

    // Checksum first, then TTL, then route
    always_comb begin
        if (!rt_stage.chk_good) begin
            reason = p4_router_pkg::DROP_BAD_CHECKSUM;
        end else if (rt_stage.ttl_expired) begin
            reason = p4_router_pkg::DROP_TTL_EXPIRED;
        end else if (egress_port == p4_router_pkg::RTL_UNKNOWN) begin
            reason = p4_router_pkg::DROP_NO_ROUTE;
        end else begin
            reason = p4_router_pkg::DROP_NONE;
        end
    end

    ////////////////////
    // Output register

    always_ff @(posedge packet_data_in or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            drop_valid  <= 1'b0;
            drop_reason <= p4_router_pkg::DROP_NONE;
        end else begin
            out_valid   <= rt_valid && (reason == p4_router_pkg::DROP_NONE);
            drop_valid  <= rt_valid && (reason != p4_router_pkg::DROP_NONE);
            drop_reason <= reason;
        end
    end

    // Header and ports go out with drops as well
    always_ff @(posedge packet_data_in) begin
        if (rt_valid) begin
            out_header       <= rt_stage.header;
            out_ingress_port <= ingress_port;
            out_egress_port  <= egress_port;
        end
    end

endmodule

// ==== p4_router_top.sv ====
// Top level of the IPv4 forwarding datapath; chains map, verify, route and
// demap stages for four cycles of latency

`timescale 1ns/1ps

module p4_router_top #(
    parameter int ROUTE_ENTRIES = 16
) (
    input  logic                             packet_data_in,
    input  logic                             rst_n,

    input  logic                             in_valid,
    input  p4_router_pkg::ipv4_header_t      in_header,
    input  p4_router_pkg::rtl_port_t         in_port,

    input  logic                             route_wr,
    input  logic [$clog2(ROUTE_ENTRIES)-1:0] route_index,
    input  p4_router_pkg::p4_port_t          route_port,

    output logic                             out_valid,
    output p4_router_pkg::ipv4_header_t      out_header,
    output p4_router_pkg::rtl_port_t         out_ingress_port,
    output p4_router_pkg::rtl_port_t         out_egress_port,
    output logic                             drop_valid,
    output p4_router_pkg::drop_reason_t      drop_reason
);

    logic                         map_valid;
    p4_router_pkg::ipv4_header_t  map_header;
    p4_router_pkg::p4_port_t      map_ingress_id;
    logic                         chk_valid;
    p4_router_pkg::ipv4_header_t  chk_header;
    p4_router_pkg::p4_port_t      chk_ingress_id;
    logic                         chk_good;
    logic                         rt_valid;
    p4_router_pkg::route_stage_t  rt_stage;

    ingress_port_mapper i_ingress_port_mapper (
        .packet_data_in ( packet_data_in ),
        .rst_n          ( rst_n          ),
        .in_valid       ( in_valid       ),
        .in_header      ( in_header      ),
        .in_port        ( in_port        ),
        .map_valid      ( map_valid      ),
        .map_header     ( map_header     ),
        .map_ingress_id ( map_ingress_id )
    );

    ipv4_checksum_verify i_ipv4_checksum_verify (
        .packet_data_in ( packet_data_in ),
        .rst_n          ( rst_n          ),
        .map_valid      ( map_valid      ),
        .map_header     ( map_header     ),
        .map_ingress_id ( map_ingress_id ),
        .chk_valid      ( chk_valid      ),
        .chk_header     ( chk_header     ),
        .chk_ingress_id ( chk_ingress_id ),
        .chk_good       ( chk_good       )
    );

    ipv4_route_update #(
        .ROUTE_ENTRIES ( ROUTE_ENTRIES )
    ) i_ipv4_route_update (
        .packet_data_in ( packet_data_in ),
        .rst_n          ( rst_n          ),
        .route_wr       ( route_wr       ),
        .route_index    ( route_index    ),
        .route_port     ( route_port     ),
        .chk_valid      ( chk_valid      ),
        .chk_header     ( chk_header     ),
        .chk_ingress_id ( chk_ingress_id ),
        .chk_good       ( chk_good       ),
        .rt_valid       ( rt_valid       ),
        .rt_stage       ( rt_stage       )
    );

    egress_port_demapper i_egress_port_demapper (
        .packet_data_in   ( packet_data_in   ),
        .rst_n            ( rst_n            ),
        .rt_valid         ( rt_valid         ),
        .rt_stage         ( rt_stage         ),
        .out_valid        ( out_valid        ),
        .out_header       ( out_header       ),
        .out_ingress_port ( out_ingress_port ),
        .out_egress_port  ( out_egress_port  ),
        .drop_valid       ( drop_valid       ),
        .drop_reason      ( drop_reason      )
    );

endmodule

// ==== p4_router_assertions.sv ====
// Concurrent checks on the router outputs, bound into the top level
// for simulation only

`timescale 1ns/1ps

module p4_router_assertions (
    input logic                        packet_data_in,
    input logic                        rst_n,
    input logic                        out_valid,
    input logic                        drop_valid,
    input p4_router_pkg::drop_reason_t drop_reason
);

    // A header is either forwarded or dropped
    one_outcome: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        !(out_valid && drop_valid))
        else $error("out_valid and drop_valid high together");

    quiet_in_reset: assert property (@(posedge packet_data_in)
        !rst_n |-> (!out_valid && !drop_valid))
        else $error("Result strobe high during reset");

    drop_has_reason: assert property (@(posedge packet_data_in) disable iff (!rst_n)
        drop_valid |-> (drop_reason != 2'd0))
        else $error("Drop reported with reason 0");

endmodule

bind p4_router_top p4_router_assertions i_p4_router_assertions (
    .packet_data_in ( packet_data_in ),
    .rst_n          ( rst_n          ),
    .out_valid      ( out_valid      ),
    .drop_valid     ( drop_valid     ),
    .drop_reason    ( drop_reason    )
);

// ==== p4_router_tb.sv ====
// Testbench for the IPv4 router datapath. It programs the route table, streams a table of
// headers and random ones, and checks every result against a reference model

`timescale 1ns/1ps

module p4_router_tb;

    localparam int ROUTE_ENTRIES = 16;
    localparam int IDX_W         = $clog2(ROUTE_ENTRIES);
    localparam int RANDOM_COUNT  = 40;
    localparam int LATENCY       = 4;

    // One directed header, with an optional route write in the same cycle
    typedef struct {
        string            name;
        logic [7:0]       port;
        logic [IDX_W-1:0] route_idx;
        logic [7:0]       ttl;
        bit               corrupt;
        bit               route_wr;
        logic [7:0]       new_route;
        int               exp_reason;
    } case_t;

    typedef struct {
        string                       name;
        int                          stamp;
        p4_router_pkg::ipv4_header_t header;
        logic [7:0]                  ingress;
        logic [7:0]                  egress;
        logic [1:0]                  reason;
    } result_t;

    logic                          packet_data_in = 1'b0;
    logic                          rst_n;
    logic                          in_valid;
    p4_router_pkg::ipv4_header_t   in_header;
    p4_router_pkg::rtl_port_t      in_port;
    logic                          route_wr;
    logic [IDX_W-1:0]              route_index;
    p4_router_pkg::p4_port_t       route_port;
    logic                          out_valid;
    p4_router_pkg::ipv4_header_t   out_header;
    p4_router_pkg::rtl_port_t      out_ingress_port;
    p4_router_pkg::rtl_port_t      out_egress_port;
    logic                          drop_valid;
    p4_router_pkg::drop_reason_t   drop_reason;

    case_t      cases[$];
    result_t    pending[$];
    logic [7:0] route_model [ROUTE_ENTRIES];
    // Entries 14 and 15 hold ids that demap to nothing
    logic [7:0] route_init [ROUTE_ENTRIES] = '{
        8'h00, 8'h10, 8'h11, 8'h20, 8'h21, 8'h30, 8'h31, 8'h40,
        8'h41, 8'h42, 8'h43, 8'h00, 8'h10, 8'h20, 8'h55, 8'hFF
    };
    integer     seed        = 32'h3839_3a32;
    int         cycle       = 0;
    int         errors      = 0;
    int         checks      = 0;
    bit         table_ready = 1'b0;

    p4_router_top #(
        .ROUTE_ENTRIES ( ROUTE_ENTRIES )
    ) i_p4_router_top (
        .packet_data_in   ( packet_data_in   ),
        .rst_n            ( rst_n            ),
        .in_valid         ( in_valid         ),
        .in_header        ( in_header        ),
        .in_port          ( in_port          ),
        .route_wr         ( route_wr         ),
        .route_index      ( route_index      ),
        .route_port       ( route_port       ),
        .out_valid        ( out_valid        ),
        .out_header       ( out_header       ),
        .out_ingress_port ( out_ingress_port ),
        .out_egress_port  ( out_egress_port  ),
        .drop_valid       ( drop_valid       ),
        .drop_reason      ( drop_reason      )
    );

    always #5 packet_data_in = ~packet_data_in;

    always @(posedge packet_data_in) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Reference model

    // Ones' complement sum of the ten header words
    function automatic logic [15:0] ones_sum(input p4_router_pkg::ipv4_header_t h);
        logic [159:0] bits;
        logic [31:0]  acc;
        bits = h;
        acc  = '0;
        for (int i = 0; i < 10; i++) begin
            acc = acc + {16'd0, bits[159 - 16*i -: 16]};
        end
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        return acc[15:0];
    endfunction

    function automatic logic [15:0] full_checksum(input p4_router_pkg::ipv4_header_t h);
        p4_router_pkg::ipv4_header_t z;
        z                 = h;
        z.header_checksum = 16'h0000;
        return ~ones_sum(z);
    endfunction

    // OISL data1 lanes come back as their data0 lane
    function automatic logic [7:0] expected_ingress(input logic [7:0] idx);
        logic [7:0] res;
        if (idx > 8'd12) begin
            res = 8'hFF;
        end else if (idx == 8'd2 || idx == 8'd4) begin
            res = idx - 8'd1;
        end else begin
            res = idx;
        end
        return res;
    endfunction

    function automatic logic [7:0] expected_egress(input logic [7:0] id);
        logic [7:0] res;
        case (id)
            8'h00:                      res = 8'd0;
            8'h20:                      res = 8'd1;
            8'h21:                      res = 8'd3;
            8'h30:                      res = 8'd5;
            8'h31:                      res = 8'd6;
            8'h10:                      res = 8'd7;
            8'h11:                      res = 8'd8;
            8'h40, 8'h41, 8'h42, 8'h43: res = id - 8'h37;
            default:                    res = 8'hFF;
        endcase
        return res;
    endfunction

    function automatic result_t build_expected(input string name,
                                               input p4_router_pkg::ipv4_header_t h,
                                               input logic [7:0] port,
                                               input int fixed_reason);
        result_t r;
        r.name    = name;
        r.stamp   = cycle;
        r.header  = h;
        r.ingress = expected_ingress(port);
        r.egress  = expected_egress(route_model[h.dst_addr[IDX_W-1:0]]);
        if (ones_sum(h) != 16'hFFFF) begin
            r.reason = 2'd1;
        end else if (h.ttl <= 8'd1) begin
            r.reason = 2'd2;
        end else if (r.egress == 8'hFF) begin
            r.reason = 2'd3;
        end else begin
            r.reason = 2'd0;
        end
        // Directed entries carry their own outcome
        if (fixed_reason >= 0) begin
            r.reason = fixed_reason[1:0];
        end
        if (r.reason == 2'd0) begin
            r.header.ttl             = h.ttl - 8'd1;
            r.header.header_checksum = full_checksum(r.header);
        end
        return r;
    endfunction

    function automatic p4_router_pkg::ipv4_header_t make_header(input logic [31:0] dst,
                                                                input logic [7:0] ttl,
                                                                input bit corrupt,
                                                                input logic [15:0] ident);
        p4_router_pkg::ipv4_header_t h;
        h.version_ihl     = 8'h45;
        h.tos             = 8'h00;
        h.total_length    = 16'd20;
        h.identification  = ident;
        h.flags_fragment  = 16'h4000;
        h.ttl             = ttl;
        h.protocol        = 8'd17;
        h.src_addr        = 32'hC0A8_0001;
        h.dst_addr        = dst;
        h.header_checksum = full_checksum(h);
        if (corrupt) begin
            h.header_checksum[0] = ~h.header_checksum[0];
        end
        return h;
    endfunction

    ////////////////////
    // Helpers

    task automatic check_value(input string name, input string what,
                               input logic [159:0] expected, input logic [159:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAIL %s %s: expected %0h, actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic add_case(input string name, input int port, input int route_idx,
                            input int ttl, input bit corrupt, input bit wr,
                            input int new_route, input int exp_reason);
        case_t c;
        c.name       = name;
        c.port       = port[7:0];
        c.route_idx  = route_idx[IDX_W-1:0];
        c.ttl        = ttl[7:0];
        c.corrupt    = corrupt;
        c.route_wr   = wr;
        c.new_route  = new_route[7:0];
        c.exp_reason = exp_reason;
        cases.push_back(c);
    endtask

    task automatic send_header(input string name, input p4_router_pkg::ipv4_header_t h,
                               input logic [7:0] port, input int fixed_reason);
        in_valid  = 1'b1;
        in_header = h;
        in_port   = port;
        pending.push_back(build_expected(name, h, port, fixed_reason));
    endtask

    ////////////////////
    // Stimulus

    initial begin
        case_t                       c;
        p4_router_pkg::ipv4_header_t h;
        logic [31:0]                 r;
        logic [7:0]                  port;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_header   = '0;
        in_port     = '0;
        route_wr    = 1'b0;
        route_index = '0;
        route_port  = '0;

        add_case("fwd_basic", 0, 1, 64, 0, 0, 0, 0);
        for (int p = 0; p < 13; p++) begin
            add_case($sformatf("port_%0d", p), p, p, 64, 0, 0, 0, 0);
        end
        add_case("port_13", 13, 2, 64, 0, 0, 0, 0);
        add_case("port_200", 200, 3, 64, 0, 0, 0, 0);
        add_case("bad_csum_ttl1", 7, 1, 1, 1, 0, 0, 1);
        add_case("bad_csum_ttl64", 7, 1, 64, 1, 0, 0, 1);
        add_case("ttl_1", 5, 1, 1, 0, 0, 0, 2);
        add_case("ttl_0", 5, 1, 0, 0, 0, 0, 2);
        add_case("ttl_2", 5, 1, 2, 0, 0, 0, 0);
        add_case("no_route_ff", 9, 15, 64, 0, 0, 0, 3);
        add_case("no_route_bad_id", 9, 14, 64, 0, 0, 0, 3);
        // Entry 15 changes to ECG2; the spacer uses another entry
        add_case("before_rewrite", 3, 15, 64, 0, 0, 0, 3);
        add_case("rewrite_spacer", 3, 1, 64, 0, 0, 0, 0);
        add_case("rewrite", 3, 15, 64, 0, 1, 'h42, 0);
        add_case("after_rewrite", 3, 15, 64, 0, 0, 0, 0);
        table_ready = 1'b1;

        repeat (10) @(negedge packet_data_in);
        rst_n = 1'b1;

        for (int i = 0; i < ROUTE_ENTRIES; i++) begin
            @(negedge packet_data_in);
            route_wr       = 1'b1;
            route_index    = i[IDX_W-1:0];
            route_port     = route_init[i];
            route_model[i] = route_init[i];
        end
        @(negedge packet_data_in);
        route_wr = 1'b0;

        // Directed table, back to back
        foreach (cases[k]) begin
            c = cases[k];
            @(negedge packet_data_in);
            route_wr    = c.route_wr;
            route_index = c.route_idx;
            route_port  = c.new_route;
            if (c.route_wr) begin
                route_model[c.route_idx] = c.new_route;
            end
            h = make_header(32'h0A00_0000 + 32'(c.route_idx), c.ttl, c.corrupt, 16'(k));
            send_header(c.name, h, c.port, c.exp_reason);
        end

        for (int k = 0; k < RANDOM_COUNT; k++) begin
            @(negedge packet_data_in);
            route_wr         = 1'b0;
            r                = $random(seed);
            h.version_ihl    = 8'h45;
            h.tos            = r[7:0];
            h.total_length   = 16'd20 + {8'd0, r[15:8]};
            h.identification = r[31:16];
            h.flags_fragment = 16'h4000;
            r                = $random(seed);
            h.ttl            = {4'd0, r[3:0]};
            h.protocol       = r[15:8];
            port             = {4'd0, r[23:20]};
            h.src_addr       = $random(seed);
            h.dst_addr       = $random(seed);
            h.header_checksum = full_checksum(h);
            // About one header in eight gets a broken checksum
            if (r[18:16] == 3'd0) begin
                h.header_checksum = h.header_checksum ^ 16'h0100;
            end
            send_header($sformatf("random_%0d", k), h, port, -1);
        end

        @(negedge packet_data_in);
        in_valid = 1'b0;
        while (pending.size() != 0) begin
            @(negedge packet_data_in);
        end
        repeat (3) @(negedge packet_data_in);

        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    ////////////////////
    // Result monitor

    always @(negedge packet_data_in) begin
        result_t r;
        if (rst_n && (out_valid || drop_valid)) begin
            if (pending.size() == 0) begin
                errors = errors + 1;
                $display("A result came out with no header pending at cycle %0d", cycle);
            end else begin
                r = pending.pop_front();
                check_value(r.name, "latency", 160'(LATENCY), 160'(cycle - r.stamp));
                check_value(r.name, "forwarded", 160'(r.reason == 2'd0), 160'(out_valid));
                check_value(r.name, "dropped", 160'(r.reason != 2'd0), 160'(drop_valid));
                check_value(r.name, "drop reason", 160'(r.reason),
                            160'(drop_valid ? drop_reason : 2'd0));
                check_value(r.name, "header", 160'(r.header), 160'(out_header));
                check_value(r.name, "ingress port", 160'(r.ingress), 160'(out_ingress_port));
                check_value(r.name, "egress port", 160'(r.egress), 160'(out_egress_port));
            end
        end
    end

    // Watchdog sized from the number of headers sent
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (cases.size() + RANDOM_COUNT + 50) * 10;
        #(limit_ns);
        $display("Timeout: the run did not finish, %0d results still pending", pending.size());
        $display("Closing: %0d checks, %0d errors", checks, errors + 1);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== p4_router.f ====
p4_router_pkg.sv
ingress_port_mapper.sv
ipv4_checksum_verify.sv
ipv4_route_update.sv
egress_port_demapper.sv
p4_router_top.sv
p4_router_assertions.sv
p4_router_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f p4_router.f \
    --top-module p4_router_tb -o p4_router_sim

status=0
output=$(./obj_dir/p4_router_sim) || status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    exit "$status"
fi

printf '%s\n' "$output" | grep -qxF "Done: no errors"
